/* Makefile */
# Verilator build and run for the SIMON32/64 packet core

VERILATOR  ?= verilator
TOP        ?= simonCore_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test completed successfully
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/simonCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "simon_config.svh"

module simonCore
(
	input  logic                             clk,
	input  logic                             nR,
	input  logic                             inReq,
	output logic                             inAck,
	input  logic [`SIMON_PKT_BYTES-1:0][7:0] inPkt,
	output logic                             pktError,
	output logic                             outReq,
	input  logic                             outAck,
	output logic [`SIMON_PKT_BYTES-1:0][7:0] outPkt
);

	logic blkReq, blkAck, keyLoad;
	logic doneData, readData;
	logic [1:0][`SIMON_N-1:0] blkIn;
	logic [1:0][`SIMON_N-1:0] blockOut;
	logic [`SIMON_M-1:0][`SIMON_N-1:0] keyIn;
	logic [7:0] infoOut, countOut;

	simonPacketDecode decode
	(
		.clk(clk), .nR(nR),
		.inReq(inReq), .inAck(inAck), .inPkt(inPkt),
		.pktError(pktError),
		.blkReq(blkReq), .blkAck(blkAck), .blkIn(blkIn),
		.keyIn(keyIn), .keyLoad(keyLoad),
		.infoOut(infoOut), .countOut(countOut)
	);

	simonRoundEngine execute
	(
		.clk(clk), .nR(nR),
		.blkReq(blkReq), .blkAck(blkAck), .blkIn(blkIn),
		.keyIn(keyIn), .keyLoad(keyLoad),
		.doneData(doneData), .readData(readData), .blockOut(blockOut)
	);

	simonPacketOut result
	(
		.clk(clk), .nR(nR),
		.doneData(doneData), .readData(readData),
		.infoOut(infoOut), .countOut(countOut), .blockOut(blockOut),
		.outReq(outReq), .outAck(outAck), .outPkt(outPkt)
	);

endmodule

`default_nettype wire

/* hdl/simonPacketDecode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "simon_config.svh"

module simonPacketDecode
(
	input  logic                              clk,
	input  logic                              nR,
	input  logic                              inReq,
	output logic                              inAck,
	input  logic [`SIMON_PKT_BYTES-1:0][7:0]  inPkt,
	output logic                              pktError,
	output logic                              blkReq,
	input  logic                              blkAck,
	output logic [1:0][`SIMON_N-1:0]          blkIn,
	output logic [`SIMON_M-1:0][`SIMON_N-1:0] keyIn,
	output logic                              keyLoad,
	output logic [7:0]                        infoOut,
	output logic [7:0]                        countOut
);

	import simonPkg::*;

	localparam int INFO = `SIMON_PKT_BYTES - 1;
	localparam int CNT = `SIMON_PKT_BYTES - 2;

	decodeState state;
	logic [`SIMON_PKT_BYTES-1:0][7:0] pkt;
	logic [7:0] pktCount;
	logic secondPending;
	logic accept;

	assign accept = (pkt[INFO][3:0] == `SIMON_MODE) && !pkt[INFO][OUTFLAG]
		&& (pkt[CNT] == pktCount);

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			state <= D_IDLE;
			inAck <= 1'b0;
			pktError <= 1'b0;
			blkReq <= 1'b0;
			keyLoad <= 1'b0;
			pktCount <= '0;
			secondPending <= 1'b0;
		end
		else
		begin
			pktError <= 1'b0;
			unique case (state)
			D_IDLE:
				if (inReq)
					state <= D_CHECK;
			D_CHECK:
			begin
				inAck <= 1'b1;
				if (accept)
				begin
					pktCount <= pktCount + 8'd1;
					keyLoad <= pkt[INFO][KEYPKT];
					secondPending <= !pkt[INFO][KEYPKT] && pkt[INFO][TWOBLK];
					state <= D_ISSUE;
				end
				else
				begin
					pktError <= 1'b1; // Dropped, no reply
					state <= D_RELEASE;
				end
			end
			D_ISSUE:
			begin
				blkReq <= 1'b1;
				state <= D_WAITACK;
			end
			D_WAITACK:
			begin
				if (blkReq && blkAck)
					blkReq <= 1'b0;
				else if (!blkReq && !blkAck)
				begin
					secondPending <= 1'b0;
					state <= secondPending ? D_ISSUE : D_RELEASE;
				end
			end
			D_RELEASE:
				if (!inReq)
				begin
					inAck <= 1'b0;
					state <= D_IDLE;
				end
			default:
				state <= D_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == D_IDLE && inReq)
			pkt <= inPkt;
		if (state == D_CHECK && accept)
		begin
			infoOut <= pkt[INFO];
			infoOut[OUTFLAG] <= 1'b1;
			countOut <= pkt[CNT];
			blkIn <= pkt[3:0]; // First block from words 1..0
			if (pkt[INFO][KEYPKT])
				keyIn <= pkt[7:0];
		end
		if (state == D_WAITACK && !blkReq && !blkAck && secondPending)
			blkIn <= pkt[7:4];
	end

endmodule

`default_nettype wire

/* hdl/simonPacketOut.sv */
`timescale 1ns/1ps
`default_nettype none
`include "simon_config.svh"

module simonPacketOut
(
	input  logic                             clk,
	input  logic                             nR,
	input  logic                             doneData,
	output logic                             readData,
	input  logic [7:0]                       infoOut,
	input  logic [7:0]                       countOut,
	input  logic [1:0][`SIMON_N-1:0]         blockOut,
	output logic                             outReq,
	input  logic                             outAck,
	output logic [`SIMON_PKT_BYTES-1:0][7:0] outPkt
);

	import simonPkg::*;

	localparam int INFO = `SIMON_PKT_BYTES - 1;
	localparam int CNT = `SIMON_PKT_BYTES - 2;

	outState state;
	logic secondPending;

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			state <= O_WAIT;
			readData <= 1'b0;
			outReq <= 1'b0;
			outPkt <= '0;
			secondPending <= 1'b0;
		end
		else
		begin
			if (readData && !doneData)
				readData <= 1'b0;
			unique case (state)
			O_WAIT:
				if (doneData && !readData)
					state <= secondPending ? O_READ : O_LOAD;
			O_LOAD:
			begin
				outPkt[INFO] <= infoOut;
				outPkt[CNT] <= countOut;
				readData <= 1'b1;
				if (infoOut[KEYPKT])
				begin
					outPkt[7:0] <= '0; // Key reply carries no data
					outReq <= 1'b1;
					state <= O_WRITE;
				end
				else if (infoOut[TWOBLK])
				begin
					outPkt[3:0] <= blockOut;
					secondPending <= 1'b1;
					state <= O_WAIT;
				end
				else
				begin
					outPkt[7:4] <= blockOut;
					outPkt[3:0] <= '0;
					outReq <= 1'b1;
					state <= O_WRITE;
				end
			end
			O_READ:
			begin
				outPkt[7:4] <= blockOut; // Second block into words 3..2
				secondPending <= 1'b0;
				readData <= 1'b1;
				outReq <= 1'b1;
				state <= O_WRITE;
			end
			O_WRITE:
				if (outReq && outAck)
					outReq <= 1'b0;
				else if (!outReq && !outAck)
					state <= O_WAIT;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/simonPkg.sv */
`default_nettype none

package simonPkg;

	typedef enum logic [2:0]
	{
		D_IDLE,
		D_CHECK,
		D_ISSUE,
		D_WAITACK,
		D_RELEASE
	} decodeState;

	typedef enum logic [1:0] {E_IDLE, E_RUN, E_DONE, E_RELEASE} engineState;

	typedef enum logic [1:0] {O_WAIT, O_LOAD, O_READ, O_WRITE} outState;

	// Bit positions inside the info byte, bits 3..0 hold the mode
	typedef enum logic [2:0]
	{
		OUTFLAG = 3'd4,
		KEYPKT  = 3'd5,
		TWOBLK  = 3'd7
	} infoBit;

endpackage

`default_nettype wire

/* hdl/simonRoundEngine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "simon_config.svh"

module simonRoundEngine
(
	input  logic                              clk,
	input  logic                              nR,
	input  logic                              blkReq,
	output logic                              blkAck,
	input  logic [1:0][`SIMON_N-1:0]          blkIn,
	input  logic [`SIMON_M-1:0][`SIMON_N-1:0] keyIn,
	input  logic                              keyLoad,
	output logic                              doneData,
	input  logic                              readData,
	output logic [1:0][`SIMON_N-1:0]          blockOut
);

	import simonPkg::*;

	localparam int RW = $clog2(`SIMON_T);
	localparam logic [61:0] Z0 = `SIMON_Z0;

	engineState state;
	logic [`SIMON_M-1:0][`SIMON_N-1:0] masterKey;
	logic [`SIMON_M-1:0][`SIMON_N-1:0] k;
	logic [`SIMON_N-1:0] x, y;
	logic [`SIMON_N-1:0] fx, xNext, tmp, kNext;
	logic [RW-1:0] round;
	logic zBit;

	function automatic logic [`SIMON_N-1:0] rotl(input logic [`SIMON_N-1:0] v, input int s);
		rotl = (v << s) | (v >> (`SIMON_N - s));
	endfunction

	assign zBit = Z0[6'd61 - 6'(round)];
	assign blockOut = {x, y};

	always_comb
	begin
		fx = (rotl(x, 1) & rotl(x, 8)) ^ rotl(x, 2);
		xNext = y ^ fx ^ k[0];
		tmp = rotl(k[3], `SIMON_N - 3) ^ k[1]; // Rotate right by 3
		kNext = ~k[0] ^ tmp ^ rotl(tmp, `SIMON_N - 1) ^ `SIMON_N'(3) ^ `SIMON_N'(zBit);
	end

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			state <= E_IDLE;
			blkAck <= 1'b0;
			doneData <= 1'b0;
			round <= '0;
		end
		else
		begin
			unique case (state)
			E_IDLE:
				if (blkReq)
				begin
					blkAck <= 1'b1;
					round <= '0;
					state <= keyLoad ? E_DONE : E_RUN;
				end
			E_RUN:
			begin
				round <= round + 1'b1;
				if (round == RW'(`SIMON_T - 1))
					state <= E_DONE;
			end
			E_DONE:
				if (!doneData)
					doneData <= 1'b1;
				else if (readData)
				begin
					doneData <= 1'b0;
					state <= E_RELEASE;
				end
			E_RELEASE:
				if (!readData && !blkReq)
				begin
					blkAck <= 1'b0; // Frees the decoder for the next request
					state <= E_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == E_IDLE && blkReq)
		begin
			if (keyLoad)
				masterKey <= keyIn;
			else
			begin
				x <= blkIn[1];
				y <= blkIn[0];
				k <= masterKey; // Schedule restarts from the master key
			end
		end
		else if (state == E_RUN)
		begin
			x <= xNext;
			y <= x;
			k <= {kNext, k[`SIMON_M-1:1]};
		end
	end

endmodule

`default_nettype wire

/* hdl/simon_config.svh */
`ifndef SIMON_CONFIG_SVH
`define SIMON_CONFIG_SVH

// SIMON32/64 cipher geometry
`define SIMON_N 16
`define SIMON_M 4
`define SIMON_T 32

`define SIMON_MODE 4'd0

// z0 round-constant sequence, leftmost bit is used in round 0
`define SIMON_Z0 62'b11111010001001010110000111001101111101000100101011000011100110

`define SIMON_PKT_BYTES 10

`endif

/* verif/simonCore_properties.sv */
`timescale 1ns/1ps
`default_nettype none
`include "simon_config.svh"

module simonCoreProperties
(
	input logic                             clk,
	input logic                             nR,
	input logic                             inReq,
	input logic                             inAck,
	input logic                             pktError,
	input logic                             outReq,
	input logic                             outAck,
	input logic [`SIMON_PKT_BYTES-1:0][7:0] outPkt,
	input simonPkg::decodeState             decState
);

	import simonPkg::*;

	int failCount;
	logic rejected;

	initial failCount = 0;

	// Open from a rejection until the decoder checks the next packet
	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
			rejected <= 1'b0;
		else if (pktError)
			rejected <= 1'b1;
		else if (decState == D_CHECK)
			rejected <= 1'b0;
	end

	inAckRise: assert property (@(posedge clk) disable iff (!nR) $rose(inAck) |-> inReq)
		else begin $error("inAck rose without inReq"); failCount = failCount + 1; end
	inAckFall: assert property (@(posedge clk) disable iff (!nR) $fell(inAck) |-> !inReq)
		else begin $error("inAck fell while inReq high"); failCount = failCount + 1; end
	outReqRise: assert property (@(posedge clk) disable iff (!nR) $rose(outReq) |-> !outAck)
		else begin $error("outReq rose while outAck high"); failCount = failCount + 1; end
	outReqFall: assert property (@(posedge clk) disable iff (!nR) $fell(outReq) |-> outAck)
		else begin $error("outReq fell without outAck"); failCount = failCount + 1; end
	outStable: assert property (@(posedge clk) disable iff (!nR) outReq |=> $stable(outPkt))
		else begin $error("outPkt changed during a transfer"); failCount = failCount + 1; end
	noReply: assert property (@(posedge clk) disable iff (!nR) rejected |-> !$rose(outReq))
		else begin $error("Reply to a rejected packet"); failCount = failCount + 1; end
	resetState: assert property (@(posedge clk)
		$rose(nR) |-> !inAck && !outReq && !pktError && outPkt == '0)
		else begin $error("Outputs not cleared by reset"); failCount = failCount + 1; end

endmodule

bind simonCore simonCoreProperties props
(
	.clk(clk), .nR(nR),
	.inReq(inReq), .inAck(inAck), .pktError(pktError),
	.outReq(outReq), .outAck(outAck), .outPkt(outPkt),
	.decState(decode.state)
);

`default_nettype wire

/* verif/simonCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "simon_config.svh"

module simonCore_tb;

	import simonPkg::*;

	localparam int TIMEOUT = 300;
	localparam int PB = `SIMON_PKT_BYTES;
	localparam logic [7:0] BLK_INFO = 8'(`SIMON_MODE);
	localparam logic [7:0] OUT_BIT = 8'(1) << OUTFLAG;
	localparam logic [7:0] KEY_INFO = BLK_INFO | (8'(1) << KEYPKT);
	localparam logic [7:0] TWO_INFO = BLK_INFO | (8'(1) << TWOBLK);

	logic clk;
	logic nR;
	logic inReq;
	logic inAck;
	logic [PB-1:0][7:0] inPkt;
	logic pktError;
	logic outReq;
	logic outAck;
	logic [PB-1:0][7:0] outPkt;
	logic [31:0] lcgState;
	logic [7:0] count; // Expected count of the next accepted packet
	logic [3:0][15:0] key;

	simonCore DUT
	(
		.clk(clk), .nR(nR),
		.inReq(inReq), .inAck(inAck), .inPkt(inPkt),
		.pktError(pktError),
		.outReq(outReq), .outAck(outAck), .outPkt(outPkt)
	);

	always #20 clk = ~clk;

	function automatic logic [15:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[31:16];
	endfunction

	function automatic logic [PB-1:0][7:0] makePkt(input logic [7:0] info,
		input logic [7:0] cnt, input logic [63:0] words);
		return {info, cnt, words};
	endfunction

	// SIMON32/64, x in the upper half of the block
	function automatic logic [31:0] encryptBlock(input logic [3:0][15:0] kw,
		input logic [31:0] pt);
		logic [15:0] rk [0:`SIMON_T-1];
		logic [61:0] z;
		logic [15:0] x, y, t, f;
		int i;
		z = `SIMON_Z0;
		x = pt[31:16];
		y = pt[15:0];
		for (i = 0; i < `SIMON_T; i++)
		begin
			if (i < 4)
				rk[i] = kw[i];
			else
			begin
				t = {rk[i-1][2:0], rk[i-1][15:3]} ^ rk[i-3];
				rk[i] = 16'hfffc ^ 16'(z[65-i]) ^ rk[i-4] ^ t ^ {t[0], t[15:1]};
			end
		end
		for (i = 0; i < `SIMON_T; i++)
		begin
			f = ({x[14:0], x[15]} & {x[7:0], x[15:8]}) ^ {x[13:0], x[15:14]};
			t = x;
			x = y ^ f ^ rk[i];
			y = t;
		end
		return {x, y};
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string test, input logic [PB*8-1:0] expected,
		input logic [PB*8-1:0] actual);
		assert (actual === expected)
		else
			abortRun($sformatf("[ERROR] %s: expected %h, actual %h", test, expected, actual));
	endtask

	// Polls inAck or outReq on falling edges
	task automatic waitFor(input bit useOut, input logic level, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while ((useOut ? outReq : inAck) !== level && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if ((useOut ? outReq : inAck) !== level)
			abortRun($sformatf("Timed out waiting for %s to go %0b", what, level));
	endtask

	task automatic sendPacket(input logic [PB-1:0][7:0] pkt, output logic rejected);
		@(posedge clk);
		inPkt <= pkt;
		inReq <= 1'b1;
		waitFor(1'b0, 1'b1, "inAck on the input handshake");
		rejected = pktError; // Pulses in the first cycle of inAck
		@(posedge clk);
		inReq <= 1'b0;
		waitFor(1'b0, 1'b0, "inAck on the input handshake");
	endtask

	task automatic receivePacket(input int delay, output logic [PB-1:0][7:0] pkt);
		waitFor(1'b1, 1'b1, "outReq on the output handshake");
		pkt = outPkt;
		repeat (delay) @(posedge clk);
		@(posedge clk);
		outAck <= 1'b1;
		waitFor(1'b1, 1'b0, "outReq on the output handshake");
		@(posedge clk);
		outAck <= 1'b0;
	endtask

	task automatic transact(input string test, input logic [PB-1:0][7:0] pkt,
		input logic [PB-1:0][7:0] expected);
		logic rejected;
		logic [PB-1:0][7:0] got;
		sendPacket(pkt, rejected);
		checkValue({test, " pktError"}, '0, 80'(rejected));
		receivePacket(int'(nextRandom() % 16'd16), got); // Random consumer stall
		checkValue(test, expected, got);
		count = count + 8'd1;
	endtask

	task automatic rejectCase(input string test, input logic [PB-1:0][7:0] pkt);
		logic rejected;
		int n;
		sendPacket(pkt, rejected);
		checkValue({test, " pktError"}, 80'(1), 80'(rejected));
		for (n = 0; n < 40; n++)
		begin
			@(negedge clk);
			assert (!outReq)
			else
				abortRun({test, ": an output packet appeared for a rejected input"});
		end
	endtask

	task automatic loadKey(input string test, input logic [3:0][15:0] newKey);
		key = newKey;
		transact(test, makePkt(KEY_INFO, count, newKey), makePkt(KEY_INFO | OUT_BIT, count, 64'd0));
	endtask

	initial
	begin
		logic [63:0] w;
		clk = 1'b0;
		nR = 1'b0;
		inReq = 1'b0;
		outAck = 1'b0;
		inPkt = '0;
		lcgState = 32'd4400;
		count = 8'd0;
		key = '0;
		repeat (3) @(posedge clk);
		nR <= 1'b1;

		checkValue("model vector", 80'(32'hc69be9bb),
			80'(encryptBlock(64'h1918111009080100, 32'h65656877)));
		loadKey("known key", 64'h1918111009080100);
		transact("known block", makePkt(BLK_INFO, count, {32'd0, 32'h65656877}),
			makePkt(BLK_INFO | OUT_BIT, count, {32'hc69be9bb, 32'd0}));

		repeat (3)
		begin
			loadKey("random key", {nextRandom(), nextRandom(), nextRandom(), nextRandom()});
			repeat (3)
			begin
				w = {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
				transact("two blocks", makePkt(TWO_INFO, count, w), makePkt(TWO_INFO | OUT_BIT,
					count, {encryptBlock(key, w[63:32]), encryptBlock(key, w[31:0])}));
			end
			w = {32'd0, nextRandom(), nextRandom()};
			transact("single block", makePkt(BLK_INFO, count, w),
				makePkt(BLK_INFO | OUT_BIT, count, {encryptBlock(key, w[31:0]), 32'd0}));
		end

		rejectCase("wrong mode", makePkt(BLK_INFO ^ 8'h01, count, w));
		rejectCase("wrong count", makePkt(BLK_INFO, count + 8'd5, w));
		rejectCase("outflag set", makePkt(BLK_INFO | OUT_BIT, count, w));
		w = {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
		transact("after reject", makePkt(TWO_INFO, count, w), makePkt(TWO_INFO | OUT_BIT,
			count, {encryptBlock(key, w[63:32]), encryptBlock(key, w[31:0])}));

		if (DUT.props.failCount == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
			abortRun("A bound handshake property failed during the run");
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/simonPkg.sv
hdl/simonPacketDecode.sv
hdl/simonRoundEngine.sv
hdl/simonPacketOut.sv
hdl/simonCore.sv
verif/simonCore_properties.sv
verif/simonCore_tb.sv
